// ==== build.sh ====
#!/bin/sh
# Compile the CPU testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project directory"
	exit 1
fi

verilator --binary -Wno-fatal --top-module cpuTb -f src.f -Mdir obj_dir -o cpuSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/cpuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

// ==== src.f ====
verilog/cpuPkg.sv
verilog/controlSequencer.sv
verilog/programCounter.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpuTop.sv
verification/cpuTb.sv

// ==== verification/cpuTb.sv ====
`timescale 1ns/100ps
module cpuTb;

	localparam int addrWidth = 8;
	localparam int period = 20;
	localparam int cyclesPerInstr = 7;  // Longest instruction from F0 to the next F0

	logic                 Clock = 1'b0;
	logic                 rstN;
	logic                 start;
	logic                 done;
	logic [addrWidth-1:0] memAddr;
	logic                 memRead;
	logic                 memWrite;
	cpuPkg::wordT         memWriteData;
	cpuPkg::wordT         memReadData = '0;

	cpuPkg::wordT         image [256];  // Program and data loaded at reset
	cpuPkg::wordT         mem [256];
	logic [addrWidth-1:0] expAddr [$];
	cpuPkg::wordT         expData [$];
	integer               seed = 32'ha575;
	int                   progLen;
	int                   modelSteps = 0;
	int                   errorCount = 0;
	int                   storeCount = 0;
	int                   doneCount = 0;
	int                   slot;
	logic                 running = 1'b0;  // Between an accepted start and done

	cpuTop #(.addrWidth(addrWidth)) dut (
		.Clock        (Clock),
		.rstN         (rstN),
		.start        (start),
		.done         (done),
		.memAddr      (memAddr),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.memWriteData (memWriteData),
		.memReadData  (memReadData)
	);

	always #(period / 2) Clock = ~Clock;

	// Memory answers a read in the next cycle
	always @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < 256; i++)
				mem[i] <= image[i];
			memReadData <= '0;
		end else begin
			if (memRead)
				memReadData <= mem[memAddr];
			if (memWrite)
				mem[memAddr] <= memWriteData;
		end
	end

	task automatic checkWord(input string name, input cpuPkg::wordT expected,
			input cpuPkg::wordT actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, got %h at %0t", name, expected, actual, $time);
			errorCount++;
		end
	endtask

	task automatic checkAddr(input string name, input logic [addrWidth-1:0] expected,
			input logic [addrWidth-1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, got %h at %0t", name, expected, actual, $time);
			errorCount++;
		end
	endtask

	task automatic putInstr(input cpuPkg::opcodeT op, input logic [3:0] ra,
			input logic [3:0] rb, input logic [3:0] rc, input logic [14:0] imm);
		cpuPkg::instrT ins;
		ins.opcode = op;
		ins.ra = ra;
		ins.rb = rb;
		ins.rc = rc;
		ins.imm = imm;
		image[progLen] = ins;
		progLen++;
	endtask

	task automatic buildProgram();
		cpuPkg::opcodeT aluOps [9];
		logic [14:0]    dst;
		aluOps = '{cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
			cpuPkg::opShl, cpuPkg::opShr, cpuPkg::opShra, cpuPkg::opRol, cpuPkg::opRor};
		for (int i = 0; i < 256; i++)
			image[i] = 32'h5A5A_0000 ^ 32'(i);
		image[8'h80] = 32'd1;
		image[8'h81] = 32'd2;
		image[8'h82] = 32'd3;
		image[8'h83] = $random(seed) | 32'h8000_0000;  // Negative so shra fills ones
		image[8'h84] = $random(seed);
		image[8'h85] = $random(seed) | 32'h0000_0001;  // Odd low bits keep the shift count nonzero
		progLen = 0;
		// Shift R3 by R5 into R1 and store it
		putInstr(cpuPkg::opLoad, 4'd3, 4'd0, 4'd0, 15'h080);
		putInstr(cpuPkg::opLoad, 4'd5, 4'd0, 4'd0, 15'h081);
		putInstr(cpuPkg::opLoad, 4'd1, 4'd0, 4'd0, 15'h082);
		putInstr(cpuPkg::opShl, 4'd1, 4'd3, 4'd5, 15'd0);
		putInstr(cpuPkg::opStore, 4'd1, 4'd0, 4'd0, 15'h0C0);
		putInstr(cpuPkg::opLoad, 4'd6, 4'd0, 4'd0, 15'h083);
		putInstr(cpuPkg::opLoad, 4'd7, 4'd0, 4'd0, 15'h084);
		putInstr(cpuPkg::opLoad, 4'd8, 4'd0, 4'd0, 15'h085);
		dst = 15'h0C1;
		foreach (aluOps[k]) begin
			putInstr(aluOps[k], 4'd9, 4'd6, (k >= 4) ? 4'd8 : 4'd7, 15'd0);
			putInstr(cpuPkg::opStore, 4'd9, 4'd0, 4'd0, dst);
			dst = dst + 15'd1;
		end
		putInstr(cpuPkg::opAddi, 4'd10, 4'd6, 4'd0, 15'h4321);  // Top immediate bit set
		putInstr(cpuPkg::opStore, 4'd10, 4'd0, 4'd0, 15'h0CA);
		// A write to R0 must not stick
		putInstr(cpuPkg::opAddi, 4'd0, 4'd6, 4'd0, 15'd7);
		putInstr(cpuPkg::opAdd, 4'd11, 4'd0, 4'd7, 15'd0);
		putInstr(cpuPkg::opStore, 4'd11, 4'd0, 4'd0, 15'h0CB);
		putInstr(cpuPkg::opStore, 4'd0, 4'd0, 4'd0, 15'h0CC);
		putInstr(cpuPkg::opHalt, 4'd0, 4'd0, 4'd0, 15'd0);
	endtask

	function automatic cpuPkg::wordT aluModel(input cpuPkg::opcodeT op,
			input cpuPkg::wordT a, input cpuPkg::wordT b);
		int           n;
		cpuPkg::wordT r;
		n = int'(b[4:0]);
		case (op)
			cpuPkg::opAdd, cpuPkg::opAddi: r = a + b;
			cpuPkg::opSub:  r = a + ~b + 32'd1;  // Two's complement
			cpuPkg::opAnd:  r = a & b;
			cpuPkg::opOr:   r = a | b;
			cpuPkg::opShl:  r = a << n;
			cpuPkg::opShr:  r = a >> n;
			cpuPkg::opShra: r = (a >> n) | (a[31] ? ~(32'hFFFF_FFFF >> n) : 32'd0);
			cpuPkg::opRol:  r = (n == 0) ? a : ((a << n) | (a >> (32 - n)));
			cpuPkg::opRor:  r = (n == 0) ? a : ((a >> n) | (a << (32 - n)));
			default:        r = b;
		endcase
		return r;
	endfunction

	// Model run of the program that fills the store queues and returns its step count
	function automatic int modelProgram();
		cpuPkg::wordT  regs [16];
		cpuPkg::wordT  data [256];
		cpuPkg::instrT ins;
		cpuPkg::wordT  b;
		logic [7:0]    pc;
		int            steps;
		logic          halted;
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			data[i] = image[i];
		expAddr.delete();
		expData.delete();
		pc = 8'd0;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < 256) begin
			ins = image[pc];
			pc = pc + 8'd1;
			steps++;
			b = (ins.opcode == cpuPkg::opAddi) ? {17'd0, ins.imm} : regs[ins.rc];
			case (ins.opcode)
				cpuPkg::opLoad:  regs[ins.ra] = data[ins.imm[7:0]];
				cpuPkg::opStore: begin
					expAddr.push_back(ins.imm[addrWidth-1:0]);
					expData.push_back(regs[ins.ra]);
					data[ins.imm[7:0]] = regs[ins.ra];
				end
				cpuPkg::opHalt:  halted = 1'b1;
				default:         regs[ins.ra] = aluModel(ins.opcode, regs[ins.rb], b);
			endcase
			regs[0] = '0;  // R0 always reads zero
		end
		return steps;
	endfunction

	// Compare process for stores, done and idle strobes
	always @(posedge Clock) begin
		if (rstN) begin
			if ((memRead || memWrite) && !running) begin
				$display("Memory strobe seen while the processor is idle at %0t", $time);
				errorCount++;
			end
			if (memWrite) begin
				if (expAddr.size() == 0) begin
					$display("Store seen although the program stores nothing at %0t", $time);
					errorCount++;
				end else begin
					slot = storeCount % expAddr.size();  // Second run repeats the list
					checkAddr("memAddr", expAddr[slot], memAddr);
					checkWord("memWriteData", expData[slot], memWriteData);
				end
				storeCount++;
			end
			if (done) begin
				if (!running) begin
					$display("Done pulsed while no program was running at %0t", $time);
					errorCount++;
				end
				doneCount++;
				running = 1'b0;
			end
			if (start)
				running = 1'b1;
		end
	end

	task automatic runProgram(input int run);
		@(posedge Clock);
		start <= 1'b1;
		@(posedge Clock);
		start <= 1'b0;
		wait (doneCount == run);
		repeat (20) @(posedge Clock);  // Idle window after done
		if (doneCount != run) begin
			$display("Done pulsed more than once in run %0d", run);
			errorCount++;
		end
	endtask

	initial begin
		rstN = 1'b0;
		start = 1'b0;
		buildProgram();
		modelSteps = modelProgram();
		repeat (8) @(posedge Clock);
		rstN <= 1'b1;
		@(negedge Clock);
		if (done || memRead || memWrite) begin
			$display("Done or a memory strobe is active right after reset");
			errorCount++;
		end
		checkAddr("memAddr", '0, memAddr);
		runProgram(1);
		checkWord("mem[C0]", 32'd4, mem[8'hC0]);  // 1 shifted left by 2
		runProgram(2);
		if (storeCount != 2 * expAddr.size()) begin
			$display("Saw %0d stores over two runs, expected %0d", storeCount,
				2 * expAddr.size());
			errorCount++;
		end
		$display("Errors: %0d, stores: %0d, done pulses: %0d", errorCount, storeCount,
			doneCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Watchdog scaled to two runs of the program
	initial begin
		wait (modelSteps > 0);
		#((2 * (modelSteps * cyclesPerInstr + 40) + 100) * period);
		$display("Timeout, the program did not finish both runs in time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
module alu (
	input  logic           Clock,
	input  logic           rstN,
	input  cpuPkg::wordT   bus,
	input  logic           yLoad,
	input  logic           zLoad,
	input  cpuPkg::opcodeT aluOp,
	output cpuPkg::wordT   zOut
);

	cpuPkg::wordT y;       // First operand, latched from the bus
	cpuPkg::wordT z;
	cpuPkg::wordT result;
	logic [4:0]   amount;  // Shift count
	logic [63:0]  rolWide;
	logic [63:0]  rorWide;

	assign amount = bus[4:0];

	// Rotates shift a doubled copy of Y and keep one half
	assign rolWide = {y, y} << amount;
	assign rorWide = {y, y} >> amount;

	always_comb begin
		case (aluOp)
			cpuPkg::opAdd,
			cpuPkg::opAddi: result = y + bus;  // Wraps modulo 2**32
			cpuPkg::opSub:  result = y - bus;
			cpuPkg::opAnd:  result = y & bus;
			cpuPkg::opOr:   result = y | bus;
			cpuPkg::opShl:  result = y << amount;
			cpuPkg::opShr:  result = y >> amount;
			cpuPkg::opShra: result = $signed(y) >>> amount;  // Sign bit repeats
			cpuPkg::opRol:  result = rolWide[63:32];
			cpuPkg::opRor:  result = rorWide[31:0];
			default:        result = bus;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			y <= '0;
			z <= '0;
		end else begin
			if (yLoad)
				y <= bus;
			if (zLoad)
				z <= result;
		end
	end

	assign zOut = z;

endmodule

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/100ps
module controlSequencer (
	input  logic          Clock,
	input  logic          rstN,
	input  logic          start,
	input  cpuPkg::instrT instr,
	output cpuPkg::ctrlT  ctrl,
	output logic          done
);

	typedef enum logic [2:0] {
		sIdle,
		sF0,
		sF1,
		sF2,
		sE0,
		sE1,
		sE2,
		sE3
	} stateT;

	stateT state;
	stateT nextState;
	logic  isLoad;
	logic  isStore;
	logic  isAddi;
	logic  isHalt;

	// IR is loaded at the end of F2, so the opcode is valid from E0 on
	assign isLoad  = instr.opcode == cpuPkg::opLoad;
	assign isStore = instr.opcode == cpuPkg::opStore;
	assign isAddi  = instr.opcode == cpuPkg::opAddi;
	assign isHalt  = instr.opcode == cpuPkg::opHalt;

	assign done = (state == sE0) && isHalt;  // One cycle, then back to idle

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN)
			state <= sIdle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			sIdle: begin
				if (start)
					nextState = sF0;
			end
			sF0: nextState = sF1;
			sF1: nextState = sF2;
			sF2: nextState = sE0;
			sE0: nextState = isHalt ? sIdle : sE1;
			sE1: nextState = sE2;
			sE2: nextState = isStore ? sF0 : sE3;  // Store is one step shorter
			sE3: nextState = sF0;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = instr.opcode;
		case (state)
			sF0: begin
				ctrl.busSrc = cpuPkg::srcPc;
				ctrl.marLoad = 1'b1;
				ctrl.pcInc = 1'b1;
			end
			sF1: ctrl.memRead = 1'b1;
			sF2: begin
				ctrl.busSrc = cpuPkg::srcMdr;  // Read data reaches the bus directly
				ctrl.mdrLoad = 1'b1;
				ctrl.irLoad = 1'b1;
			end
			sE0: begin
				if (isLoad || isStore) begin
					ctrl.busSrc = cpuPkg::srcImm;
					ctrl.marLoad = 1'b1;
				end else if (!isHalt) begin
					ctrl.busSrc = cpuPkg::srcReg;  // rb into Y
					ctrl.regSel = instr.rb;
					ctrl.yLoad = 1'b1;
				end
			end
			sE1: begin
				if (isLoad) begin
					ctrl.memRead = 1'b1;
				end else if (isStore) begin
					ctrl.busSrc = cpuPkg::srcReg;
					ctrl.regSel = instr.ra;
					ctrl.mdrLoad = 1'b1;
				end else begin
					ctrl.busSrc = isAddi ? cpuPkg::srcImm : cpuPkg::srcReg;
					ctrl.regSel = instr.rc;
					ctrl.zLoad = 1'b1;
				end
			end
			sE2: begin
				if (isStore) begin
					ctrl.memWrite = 1'b1;
				end else begin
					ctrl.busSrc = isLoad ? cpuPkg::srcMdr : cpuPkg::srcZ;
					ctrl.regSel = instr.ra;
					ctrl.regWrite = 1'b1;
					ctrl.mdrLoad = isLoad;
				end
			end
			default: ctrl.busSrc = cpuPkg::srcNone;  // Idle and E3 drive nothing
		endcase
	end

endmodule

// ==== verilog/cpuPkg.sv ====
package cpuPkg;

	typedef logic [31:0] wordT;

	// Opcode values follow the teaching ISA encoding, shl is 5'b01001
	typedef enum logic [4:0] {
		opLoad  = 5'b00000,
		opStore = 5'b00010,
		opAdd   = 5'b00011,
		opSub   = 5'b00100,
		opAnd   = 5'b00101,
		opOr    = 5'b00110,
		opShr   = 5'b00111,
		opShra  = 5'b01000,
		opShl   = 5'b01001,
		opRol   = 5'b01010,
		opRor   = 5'b01011,
		opAddi  = 5'b01100,
		opHalt  = 5'b11011
	} opcodeT;

	typedef struct packed {
		opcodeT      opcode;  // Bits 31:27
		logic [3:0]  ra;      // Destination, or source of a store
		logic [3:0]  rb;
		logic [3:0]  rc;
		logic [14:0] imm;     // Absolute address for load/store, constant for addi
	} instrT;

	typedef enum logic [2:0] {
		srcNone,
		srcReg,
		srcPc,
		srcMdr,
		srcZ,
		srcImm
	} busSrcT;

	// Control word, one per sequencer state
	typedef struct packed {
		busSrcT     busSrc;
		logic [3:0] regSel;
		logic       regWrite;
		logic       marLoad;
		logic       mdrLoad;
		logic       irLoad;
		logic       yLoad;
		logic       zLoad;
		logic       pcInc;
		logic       memRead;
		logic       memWrite;
		opcodeT     aluOp;
	} ctrlT;

endpackage

// ==== verilog/cpuTop.sv ====
`timescale 1ns/100ps
module cpuTop #(
	parameter int addrWidth = 8
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 start,
	output logic                 done,
	output logic [addrWidth-1:0] memAddr,
	output logic                 memRead,
	output logic                 memWrite,
	output cpuPkg::wordT         memWriteData,
	input  cpuPkg::wordT         memReadData
);

	cpuPkg::ctrlT         ctrl;
	cpuPkg::instrT        instr;
	cpuPkg::wordT         bus;      // Single shared bus
	cpuPkg::wordT         regData;
	cpuPkg::wordT         zOut;
	logic [addrWidth-1:0] pc;

	controlSequencer sequencer (
		.Clock (Clock),
		.rstN  (rstN),
		.start (start),
		.instr (instr),
		.ctrl  (ctrl),
		.done  (done)
	);

	programCounter #(.addrWidth(addrWidth)) pcReg (
		.Clock (Clock),
		.rstN  (rstN),
		.start (start),
		.pcInc (ctrl.pcInc),
		.pc    (pc)
	);

	registerFile regs (
		.Clock    (Clock),
		.rstN     (rstN),
		.regSel   (ctrl.regSel),
		.regWrite (ctrl.regWrite),
		.bus      (bus),
		.readData (regData)
	);

	alu aluUnit (
		.Clock (Clock),
		.rstN  (rstN),
		.bus   (bus),
		.yLoad (ctrl.yLoad),
		.zLoad (ctrl.zLoad),
		.aluOp (ctrl.aluOp),
		.zOut  (zOut)
	);

	datapath #(.addrWidth(addrWidth)) dp (
		.Clock        (Clock),
		.rstN         (rstN),
		.ctrl         (ctrl),
		.pc           (pc),
		.regData      (regData),
		.zOut         (zOut),
		.memReadData  (memReadData),
		.bus          (bus),
		.instr        (instr),
		.memAddr      (memAddr),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.memWriteData (memWriteData)
	);

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/100ps
module datapath #(
	parameter int addrWidth = 8
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  cpuPkg::ctrlT         ctrl,
	input  logic [addrWidth-1:0] pc,
	input  cpuPkg::wordT         regData,
	input  cpuPkg::wordT         zOut,
	input  cpuPkg::wordT         memReadData,
	output cpuPkg::wordT         bus,
	output cpuPkg::instrT        instr,
	output logic [addrWidth-1:0] memAddr,
	output logic                 memRead,
	output logic                 memWrite,
	output cpuPkg::wordT         memWriteData
);

	logic [addrWidth-1:0] mar;
	cpuPkg::wordT         mdr;
	cpuPkg::wordT         mdrIn;
	cpuPkg::instrT        ir;
	logic                 readPending;  // Memory answers in this cycle
	cpuPkg::wordT         mdrView;      // What MDR shows on the bus

	// Read data arrives one cycle after the strobe. In that cycle it goes
	// straight onto the bus and MDR captures it at the closing edge.
	assign mdrView = readPending ? memReadData : mdr;
	assign mdrIn = readPending ? memReadData : bus;

	always_comb begin
		case (ctrl.busSrc)
			cpuPkg::srcReg: bus = regData;
			cpuPkg::srcPc:  bus = {{(32 - addrWidth){1'b0}}, pc};
			cpuPkg::srcMdr: bus = mdrView;
			cpuPkg::srcZ:   bus = zOut;
			cpuPkg::srcImm: bus = {17'd0, ir.imm};  // Zero extended
			default:        bus = '0;
		endcase
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			readPending <= 1'b0;
			mar <= '0;
			ir <= '0;
		end else begin
			readPending <= ctrl.memRead;
			if (ctrl.marLoad)
				mar <= bus[addrWidth-1:0];
			if (ctrl.irLoad)
				ir <= bus;
		end
	end

	always_ff @(posedge Clock) begin
		if (ctrl.mdrLoad)
			mdr <= mdrIn;  // Read data or store data
	end

	assign instr = ir;
	assign memAddr = mar;
	assign memWriteData = mdr;
	assign memRead = ctrl.memRead;
	assign memWrite = ctrl.memWrite;

endmodule

// ==== verilog/programCounter.sv ====
`timescale 1ns/100ps
module programCounter #(
	parameter int addrWidth = 8
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 start,
	input  logic                 pcInc,
	output logic [addrWidth-1:0] pc
);

	// Start takes priority so that a new run always begins at word 0.
	// The increment wraps naturally at the top of the address range.
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else if (start) begin
			pc <= '0;
		end else if (pcInc) begin
			pc <= pc + 1'b1;  // Fetch step F0
		end
	end

endmodule

// ==== verilog/registerFile.sv ====
`timescale 1ns/100ps
module registerFile (
	input  logic         Clock,
	input  logic         rstN,
	input  logic [3:0]   regSel,
	input  logic         regWrite,
	input  cpuPkg::wordT bus,
	output cpuPkg::wordT readData
);

	// R0 has no storage, it is a constant zero
	cpuPkg::wordT regs [15:1];

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 1; i < 16; i++)
				regs[i] <= '0;
		end else if (regWrite && (regSel != 4'd0)) begin
			regs[regSel] <= bus;  // Writes to R0 are dropped
		end
	end

	assign readData = (regSel == 4'd0) ? '0 : regs[regSel];

endmodule
